// File: scaler_pkg.sv
`default_nettype none

package scaler_pkg;

	// Source and output frame sizes.
	localparam int SW_WIDTH = 10;
	localparam int SH_WIDTH = 10;
	localparam int MW_WIDTH = 10;
	localparam int MH_WIDTH = 10;

	// Line buffer ring.
	localparam int LINE_COUNT    = 4;
	localparam int LINE_ID_WIDTH = 2;

	// Blend phase in quarters, 0 to 4.
	localparam int PHASE_WIDTH = 3;

	// Quarter-pixel position and remainder of the stepping accumulator.
	localparam int POS_WIDTH = SW_WIDTH + 2;
	localparam int ACC_WIDTH = 13;

	// Output register slice, 0 turns it into wires.
	localparam int OUT_RELAY = 1;

endpackage

`default_nettype wire

// File: pixel_pkg.sv
`default_nettype none

package pixel_pkg;

	localparam int PIXEL_WIDTH = 16;
	localparam int R_WIDTH     = 5;
	localparam int G_WIDTH     = 6;
	localparam int B_WIDTH     = 5;

	// Red sits in the top bits.
	typedef struct packed {
		logic [R_WIDTH-1:0] r;
		logic [G_WIDTH-1:0] g;
		logic [B_WIDTH-1:0] b;
	} rgb565_t;

	// Stored as a raw word, blended per channel.
	typedef union packed {
		logic [PIXEL_WIDTH-1:0] raw;
		rgb565_t                ch;
	} pixel_t;

endpackage

`default_nettype wire

// File: linebuffer.sv
`default_nettype none

module linebuffer (
	input  logic                            clk,
	input  logic                            i_wr_en,
	input  logic [scaler_pkg::SW_WIDTH-1:0] i_wr_addr,
	input  pixel_pkg::pixel_t               i_wr_data,
	input  logic                            i_rd_en,
	input  logic [scaler_pkg::SW_WIDTH-1:0] i_rd_addr,
	output pixel_pkg::pixel_t               o_rd_data
);
	import scaler_pkg::*;
	import pixel_pkg::*;

	logic [PIXEL_WIDTH-1:0] mem [2**SW_WIDTH];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data.raw;
		// Read data holds while no strobe arrives.
		if (i_rd_en)
			o_rd_data.raw <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// File: scaler_relay.sv
`default_nettype none

module scaler_relay #(
	parameter int DATA_WIDTH  = 18,
	parameter bit PASSTHROUGH = 1'b0
) (
	input  logic                  clk,
	input  logic                  frm_resetn,
	input  logic                  i_valid,
	input  logic [DATA_WIDTH-1:0] i_data,
	output logic                  o_ready,
	output logic                  o_valid,
	output logic [DATA_WIDTH-1:0] o_data,
	input  logic                  i_ready
);
	generate
		if (PASSTHROUGH) begin : g_wire
			assign o_valid = i_valid;
			assign o_data  = i_data;
			assign o_ready = i_ready;
		end else begin : g_slice
			logic                  main_valid, skid_valid;
			logic [DATA_WIDTH-1:0] main_data, skid_data;

			assign o_valid = main_valid;
			assign o_data  = main_data;
			// Ready comes from a register only.
			assign o_ready = !skid_valid;

			always_ff @(posedge clk) begin
				if (!frm_resetn) begin
					main_valid <= 1'b0;
					skid_valid <= 1'b0;
				end else if (!main_valid || i_ready) begin
					main_valid <= skid_valid || i_valid;
					main_data  <= skid_valid ? skid_data : i_data;
					skid_valid <= 1'b0;
				end else if (i_valid && !skid_valid) begin
					skid_valid <= 1'b1;
					skid_data  <= i_data;
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

// File: scaler_2d.sv
`default_nettype none

module scaler_2d (
	input  logic                                  clk,
	input  logic                                  frm_resetn,
	input  logic [scaler_pkg::SW_WIDTH-1:0]       i_s_width,
	input  logic [scaler_pkg::SH_WIDTH-1:0]       i_s_height,
	input  logic [scaler_pkg::MW_WIDTH-1:0]       i_m_width,
	input  logic [scaler_pkg::MH_WIDTH-1:0]       i_m_height,
	output logic                                  o_valid,
	input  logic                                  i_ready,
	output logic                                  o_d_valid,
	output logic                                  o_user,
	output logic                                  o_last,
	output logic [scaler_pkg::PHASE_WIDTH-1:0]    o_r_phase,
	output logic [scaler_pkg::PHASE_WIDTH-1:0]    o_c_phase,
	output logic [scaler_pkg::LINE_COUNT-1:0]     o_r_bmp0,
	output logic [scaler_pkg::LINE_COUNT-1:0]     o_r_bmp1,
	output logic [scaler_pkg::LINE_ID_WIDTH-1:0]  o_r_bid0,
	output logic [scaler_pkg::LINE_ID_WIDTH-1:0]  o_r_bid1,
	output logic                                  o_r_update0,
	output logic [scaler_pkg::SW_WIDTH-1:0]       o_c_idx1,
	output logic                                  o_c_new1
);
	import scaler_pkg::*;

	logic [MW_WIDTH-1:0]  col;
	logic [MH_WIDTH-1:0]  row;
	logic                 pre;
	logic                 done;
	logic [POS_WIDTH-1:0] cx_pos, cx_pos_nx, ry_pos, ry_pos_nx;
	logic [ACC_WIDTH-1:0] cx_rem, cx_rem_nx, ry_rem, ry_rem_nx;
	logic [ACC_WIDTH-1:0] num_x, den_x, num_y, den_y;
	logic [SW_WIDTH-1:0]  c_int, c1, c_loaded;
	logic [SH_WIDTH-1:0]  r_int, r_int_nx, r0, r0_nx, r1;
	logic                 c_edge, r_edge, row_end, step;

	// Adds one output step and takes 0 to 4 whole quarters out of the remainder.
	function automatic logic [POS_WIDTH+ACC_WIDTH-1:0] advance(
		input logic [POS_WIDTH-1:0] pos,
		input logic [ACC_WIDTH-1:0] rem,
		input logic [ACC_WIDTH-1:0] num,
		input logic [ACC_WIDTH-1:0] den
	);
		logic [ACC_WIDTH-1:0] sum;
		logic [ACC_WIDTH-1:0] sub;
		logic [2:0]           k;
		sum = rem + num;
		if (sum >= (den << 2)) begin
			k = 3'd4;
			sub = den << 2;
		end else if (sum >= den + (den << 1)) begin
			k = 3'd3;
			sub = den + (den << 1);
		end else if (sum >= (den << 1)) begin
			k = 3'd2;
			sub = den << 1;
		end else if (sum >= den) begin
			k = 3'd1;
			sub = den;
		end else begin
			k = 3'd0;
			sub = '0;
		end
		return {pos + POS_WIDTH'(k), sum - sub};
	endfunction

	assign num_x = (ACC_WIDTH'(i_s_width) - 1'b1) << 2;
	assign den_x = ACC_WIDTH'(i_m_width) - 1'b1;
	assign num_y = (ACC_WIDTH'(i_s_height) - 1'b1) << 2;
	assign den_y = ACC_WIDTH'(i_m_height) - 1'b1;

	always_comb begin
		{cx_pos_nx, cx_rem_nx} = advance(cx_pos, cx_rem, num_x, den_x);
		{ry_pos_nx, ry_rem_nx} = advance(ry_pos, ry_rem, num_y, den_y);
	end

	// The last source column or row blends with phase 4 from its left neighbour.
	assign c_int    = cx_pos[POS_WIDTH-1:2];
	assign c_edge   = (c_int == i_s_width - 1'b1);
	assign c1       = c_edge ? c_int : c_int + 1'b1;
	assign r_int    = ry_pos[POS_WIDTH-1:2];
	assign r_edge   = (r_int == i_s_height - 1'b1);
	assign r0       = r_edge ? r_int - 1'b1 : r_int;
	assign r1       = r0 + 1'b1;
	assign r_int_nx = ry_pos_nx[POS_WIDTH-1:2];
	assign r0_nx    = (r_int_nx == i_s_height - 1'b1) ? r_int_nx - 1'b1 : r_int_nx;

	assign o_c_phase = c_edge ? PHASE_WIDTH'(4) : PHASE_WIDTH'(cx_pos[1:0]);
	assign o_r_phase = r_edge ? PHASE_WIDTH'(4) : PHASE_WIDTH'(ry_pos[1:0]);
	assign o_r_bid0  = r0[LINE_ID_WIDTH-1:0];
	assign o_r_bid1  = r1[LINE_ID_WIDTH-1:0];
	assign o_r_bmp0  = LINE_COUNT'(1) << o_r_bid0;
	assign o_r_bmp1  = LINE_COUNT'(1) << o_r_bid1;

	// A prefetch position loads column 0 before each output row.
	assign row_end     = !pre && (col == i_m_width - 1'b1);
	assign o_valid     = !done;
	assign o_d_valid   = !pre;
	assign o_user      = !pre && (col == '0) && (row == '0);
	assign o_last      = row_end;
	assign o_c_idx1    = pre ? '0 : c1;
	assign o_c_new1    = pre || (c1 != c_loaded);
	assign o_r_update0 = row_end && (row != i_m_height - 1'b1) && (r0_nx != r0);
	assign step        = o_valid && i_ready;

	always_ff @(posedge clk) begin
		if (!frm_resetn) begin
			col      <= '0;
			row      <= '0;
			pre      <= 1'b1;
			done     <= 1'b0;
			cx_pos   <= '0;
			cx_rem   <= '0;
			ry_pos   <= '0;
			ry_rem   <= '0;
			c_loaded <= '0;
		end else if (step) begin
			if (pre) begin
				pre      <= 1'b0;
				c_loaded <= '0;
			end else begin
				if (o_c_new1)
					c_loaded <= c1;
				if (row_end) begin
					col    <= '0;
					cx_pos <= '0;
					cx_rem <= '0;
					pre    <= 1'b1;
					if (row == i_m_height - 1'b1) begin
						done <= 1'b1;
					end else begin
						row    <= row + 1'b1;
						ry_pos <= ry_pos_nx;
						ry_rem <= ry_rem_nx;
					end
				end else begin
					col    <= col + 1'b1;
					cx_pos <= cx_pos_nx;
					cx_rem <= cx_rem_nx;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: axis_scaler.sv
`default_nettype none

module axis_scaler (
	input  logic                            clk,
	input  logic                            frm_resetn,
	input  logic                            i_fsync,
	input  logic [scaler_pkg::SW_WIDTH-1:0] i_s_width,
	input  logic [scaler_pkg::SH_WIDTH-1:0] i_s_height,
	input  logic [scaler_pkg::MW_WIDTH-1:0] i_m_width,
	input  logic [scaler_pkg::MH_WIDTH-1:0] i_m_height,
	input  logic                            i_s_valid,
	input  pixel_pkg::pixel_t               i_s_data,
	input  logic                            i_s_user,
	input  logic                            i_s_last,
	output logic                            o_s_ready,
	output logic                            o_m_valid,
	output pixel_pkg::pixel_t               o_m_data,
	output logic                            o_m_user,
	output logic                            o_m_last,
	input  logic                            i_m_ready
);
	import scaler_pkg::*;
	import pixel_pkg::*;

	function automatic logic [G_WIDTH-1:0] blend_ch(
		input logic [PHASE_WIDTH-1:0] ph,
		input logic [G_WIDTH-1:0]     a,
		input logic [G_WIDTH-1:0]     b
	);
		logic [G_WIDTH+1:0] ea;
		logic [G_WIDTH+1:0] eb;
		logic [G_WIDTH+1:0] sum;
		ea = {2'b00, a};
		eb = {2'b00, b};
		case (ph)
			3'd0:    sum = ea;
			3'd1:    sum = (ea + ea + ea + eb) >> 2;
			3'd2:    sum = (ea + eb) >> 1;
			3'd3:    sum = (ea + eb + eb + eb) >> 2;
			default: sum = eb;
		endcase
		return sum[G_WIDTH-1:0];
	endfunction

	function automatic pixel_t blend_px(
		input logic [PHASE_WIDTH-1:0] ph,
		input pixel_t                 v0,
		input pixel_t                 v1
	);
		pixel_t res;
		res.ch.r = R_WIDTH'(blend_ch(ph, G_WIDTH'(v0.ch.r), G_WIDTH'(v1.ch.r)));
		res.ch.g = blend_ch(ph, v0.ch.g, v1.ch.g);
		res.ch.b = B_WIDTH'(blend_ch(ph, G_WIDTH'(v0.ch.b), G_WIDTH'(v1.ch.b)));
		return res;
	endfunction

	// Frame state waits for the first fsync.
	logic frm_armed, frame_resetn;

	always_ff @(posedge clk) begin
		if (!frm_resetn)
			frm_armed <= 1'b0;
		else if (i_fsync)
			frm_armed <= 1'b1;
	end
	assign frame_resetn = frm_armed && !i_fsync;

	////////////////////////////////////////
	// Coordinate generator.
	logic                     algo_valid, algo_ready, algo_d_valid, algo_user, algo_last;
	logic [PHASE_WIDTH-1:0]   algo_r_phase, algo_c_phase;
	logic [LINE_COUNT-1:0]    algo_r_bmp0, algo_r_bmp1;
	logic [LINE_ID_WIDTH-1:0] algo_r_bid0, algo_r_bid1;
	logic                     algo_r_update0, algo_c_new1;
	logic [SW_WIDTH-1:0]      algo_c_idx1;

	scaler_2d algo_i (
		.clk        (clk),
		.frm_resetn (frame_resetn),
		.i_s_width  (i_s_width),
		.i_s_height (i_s_height),
		.i_m_width  (i_m_width),
		.i_m_height (i_m_height),
		.o_valid    (algo_valid),
		.i_ready    (algo_ready),
		.o_d_valid  (algo_d_valid),
		.o_user     (algo_user),
		.o_last     (algo_last),
		.o_r_phase  (algo_r_phase),
		.o_c_phase  (algo_c_phase),
		.o_r_bmp0   (algo_r_bmp0),
		.o_r_bmp1   (algo_r_bmp1),
		.o_r_bid0   (algo_r_bid0),
		.o_r_bid1   (algo_r_bid1),
		.o_r_update0(algo_r_update0),
		.o_c_idx1   (algo_c_idx1),
		.o_c_new1   (algo_c_new1)
	);

	////////////////////////////////////////
	// Line buffer ring.
	logic [LINE_COUNT-1:0] wr_act, wr_act_nx, wr_en, line_full;
	logic [SW_WIDTH-1:0]   wr_idx, wr_addr;
	pixel_t                wr_data;
	logic                  wr_last, wr_first;
	logic                  s_take, s_row_end, consume, release_row;
	pixel_t                rd_data [LINE_COUNT];

	assign s_take      = i_s_valid && o_s_ready;
	assign s_row_end   = s_take && i_s_last;
	assign wr_addr     = wr_first ? '0 : wr_idx;
	assign consume     = algo_valid && algo_ready;
	assign release_row = consume && algo_r_update0;

	always_ff @(posedge clk) begin
		if (!frame_resetn) begin
			wr_last  <= 1'b0;
			wr_first <= 1'b0;
			wr_en    <= '0;
		end else begin
			wr_en <= s_take ? wr_act : '0;
			if (s_take) begin
				wr_last  <= i_s_last;
				wr_first <= i_s_user;
			end
		end
		if (s_take)
			wr_data <= i_s_data;
	end

	always_ff @(posedge clk) begin
		if (!frame_resetn)
			wr_idx <= '0;
		else if (wr_en != '0)
			wr_idx <= wr_last ? '0 : wr_addr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!frame_resetn) begin
			wr_act    <= LINE_COUNT'(1);
			wr_act_nx <= LINE_COUNT'(2);
			line_full <= '0;
		end else begin
			if (s_row_end) begin
				wr_act    <= wr_act_nx;
				wr_act_nx <= {wr_act_nx[LINE_COUNT-2:0], wr_act_nx[LINE_COUNT-1]};
			end
			line_full <= (line_full | (s_row_end ? wr_act : '0))
				& ~(release_row ? algo_r_bmp0 : '0);
		end
	end

	// Stop after a row end if the next slot still holds a row.
	always_ff @(posedge clk) begin
		if (!frame_resetn)
			o_s_ready <= 1'b0;
		else if (o_s_ready) begin
			if (s_row_end && ((~line_full & wr_act_nx) == '0))
				o_s_ready <= 1'b0;
		end else if ((~line_full & wr_act) != '0)
			o_s_ready <= 1'b1;
	end

	for (genvar k = 0; k < LINE_COUNT; k++) begin : g_line
		linebuffer line_i (
			.clk      (clk),
			.i_wr_en  (wr_en[k]),
			.i_wr_addr(wr_addr),
			.i_wr_data(wr_data),
			.i_rd_en  (consume),
			.i_rd_addr(algo_c_idx1),
			.o_rd_data(rd_data[k])
		);
	end

	////////////////////////////////////////
	// Blend pipeline.
	logic pipe_en, line_valid, relay_ready;

	logic                     o0_valid, o0_new, o0_user, o0_last;
	logic [LINE_ID_WIDTH-1:0] o0_bid0, o0_bid1;
	logic [PHASE_WIDTH-1:0]   o0_rph, o0_cph;
	logic                     o1_valid, o1_user, o1_last;
	pixel_t                   o1_w00, o1_w01, o1_w10, o1_w11;
	logic [PHASE_WIDTH-1:0]   o1_rph, o1_cph;
	logic                     o2_valid, o2_user, o2_last;
	pixel_t                   o2_h0, o2_h1;
	logic [PHASE_WIDTH-1:0]   o2_rph;
	logic                     o3_valid, o3_user, o3_last;
	pixel_t                   o3_data;

	assign pipe_en    = !o3_valid || relay_ready;
	assign line_valid = (algo_r_bmp1 & line_full) != '0;
	assign algo_ready = line_valid && pipe_en;

	always_ff @(posedge clk) begin
		if (!frame_resetn) begin
			o0_valid <= 1'b0;
			o0_new   <= 1'b0;
			o1_valid <= 1'b0;
			o2_valid <= 1'b0;
			o3_valid <= 1'b0;
		end else if (pipe_en) begin
			// Stage 0, position.
			o0_valid <= consume && algo_d_valid;
			o0_new   <= consume && algo_c_new1;
			o0_bid0  <= algo_r_bid0;
			o0_bid1  <= algo_r_bid1;
			o0_rph   <= algo_r_phase;
			o0_cph   <= algo_c_phase;
			o0_user  <= algo_user;
			o0_last  <= algo_last;
			// Stage 1, 2x2 window.
			o1_valid <= o0_valid;
			if (o0_new) begin
				o1_w00 <= o1_w01;
				o1_w01 <= rd_data[o0_bid0];
				o1_w10 <= o1_w11;
				o1_w11 <= rd_data[o0_bid1];
			end
			o1_rph  <= o0_rph;
			o1_cph  <= o0_cph;
			o1_user <= o0_user;
			o1_last <= o0_last;
			// Stage 2, across.
			o2_valid <= o1_valid;
			o2_h0    <= blend_px(o1_cph, o1_w00, o1_w01);
			o2_h1    <= blend_px(o1_cph, o1_w10, o1_w11);
			o2_rph   <= o1_rph;
			o2_user  <= o1_user;
			o2_last  <= o1_last;
			// Stage 3, down.
			o3_valid <= o2_valid;
			o3_data  <= blend_px(o2_rph, o2_h0, o2_h1);
			o3_user  <= o2_user;
			o3_last  <= o2_last;
		end
	end

	logic [PIXEL_WIDTH+1:0] relay_data;

	scaler_relay #(
		.DATA_WIDTH (PIXEL_WIDTH + 2),
		.PASSTHROUGH(OUT_RELAY == 0)
	) relay_i (
		.clk       (clk),
		.frm_resetn(frame_resetn),
		.i_valid   (o3_valid),
		.i_data    ({o3_data.raw, o3_last, o3_user}),
		.o_ready   (relay_ready),
		.o_valid   (o_m_valid),
		.o_data    (relay_data),
		.i_ready   (i_m_ready)
	);

	assign o_m_data.raw = relay_data[PIXEL_WIDTH+1:2];
	assign o_m_last     = relay_data[1];
	assign o_m_user     = relay_data[0];

endmodule

`default_nettype wire

// File: axis_scaler_properties.sv
`default_nettype none

module axis_scaler_properties (
	input logic              clk,
	input logic              frm_resetn,
	input logic              i_fsync,
	input logic              o_s_ready,
	input logic              o_m_valid,
	input pixel_pkg::pixel_t o_m_data,
	input logic              o_m_user,
	input logic              o_m_last,
	input logic              i_m_ready
);
	timeunit 1ns;
	timeprecision 1ns;

	logic stalled;

	// An fsync clears the relay, so it ends a stall.
	assign stalled = frm_resetn && !i_fsync && o_m_valid && !i_m_ready;

	assert property (@(posedge clk) stalled |=> o_m_valid)
		else $error("output beat dropped before ready");

	assert property (@(posedge clk)
		stalled |=> $stable(o_m_data) && $stable(o_m_user) && $stable(o_m_last))
		else $error("output payload changed while stalled");

	// Outputs settle low once reset has been seen for a full cycle.
	assert property (@(posedge clk) !frm_resetn |=> ##1 (!o_m_valid && !o_s_ready))
		else $error("stream outputs active during reset");

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic frm_resetn
);
	timeunit 1ns;
	timeprecision 1ns;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset covers the first two rising edges.
	initial begin
		frm_resetn = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		frm_resetn = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_axis_scaler.sv
`default_nettype none

module tb_axis_scaler;
	timeunit 1ns;
	timeprecision 1ns;

	import scaler_pkg::*;
	import pixel_pkg::*;

	localparam int LIMIT = 4000;

	logic                clk, frm_resetn, fsync;
	logic [SW_WIDTH-1:0] s_width;
	logic [SH_WIDTH-1:0] s_height;
	logic [MW_WIDTH-1:0] m_width;
	logic [MH_WIDTH-1:0] m_height;
	logic                s_valid, s_user, s_last, s_ready;
	logic                m_valid, m_user, m_last, m_ready;
	pixel_t              s_data, m_data;

	pixel_t      src [128];
	pixel_t      got [128];
	logic        got_user [128];
	logic        got_last [128];
	int          got_count;
	int          errors, tests_run, tests_bad;
	logic [16:0] lfsr = 17'd81311;

	tb_clkgen clkgen_i (
		.clk       (clk),
		.frm_resetn(frm_resetn)
	);

	axis_scaler dut_i (
		.clk       (clk),
		.frm_resetn(frm_resetn),
		.i_fsync   (fsync),
		.i_s_width (s_width),
		.i_s_height(s_height),
		.i_m_width (m_width),
		.i_m_height(m_height),
		.i_s_valid (s_valid),
		.i_s_data  (s_data),
		.i_s_user  (s_user),
		.i_s_last  (s_last),
		.o_s_ready (s_ready),
		.o_m_valid (m_valid),
		.o_m_data  (m_data),
		.o_m_user  (m_user),
		.o_m_last  (m_last),
		.i_m_ready (m_ready)
	);

	bind axis_scaler axis_scaler_properties props_i (
		.clk       (clk),
		.frm_resetn(frm_resetn),
		.i_fsync   (i_fsync),
		.o_s_ready (o_s_ready),
		.o_m_valid (o_m_valid),
		.o_m_data  (o_m_data),
		.o_m_user  (o_m_user),
		.o_m_last  (o_m_last),
		.i_m_ready (i_m_ready)
	);

	// Fibonacci LFSR with taps 17 and 14 stepped once per bit.
	function automatic logic [15:0] next_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int blend(input int ph, input int a, input int b);
		case (ph)
			0:       return a;
			1:       return (3 * a + b) / 4;
			2:       return (a + b) / 2;
			3:       return (a + 3 * b) / 4;
			default: return b;
		endcase
	endfunction

	function automatic pixel_t mix(input int ph, input pixel_t a, input pixel_t b);
		pixel_t res;
		res.ch.r = R_WIDTH'(blend(ph, a.ch.r, b.ch.r));
		res.ch.g = G_WIDTH'(blend(ph, a.ch.g, b.ch.g));
		res.ch.b = B_WIDTH'(blend(ph, a.ch.b, b.ch.b));
		return res;
	endfunction

	// Blends across and then down to give the expected pixel at column j of row i.
	function automatic pixel_t model_pixel(input int j, input int i);
		int     sw, sh, mw, mh, px, py, c0, c1, r0, r1;
		pixel_t h0, h1;
		sw = int'(s_width);
		sh = int'(s_height);
		mw = int'(m_width);
		mh = int'(m_height);
		px = 4 * j * (sw - 1) / (mw - 1);
		py = 4 * i * (sh - 1) / (mh - 1);
		c0 = px / 4;
		r0 = py / 4;
		// The last column or row pairs with itself.
		c1 = (c0 < sw - 1) ? c0 + 1 : c0;
		r1 = (r0 < sh - 1) ? r0 + 1 : r0;
		h0 = mix(px % 4, src[r0 * sw + c0], src[r0 * sw + c1]);
		h1 = mix(px % 4, src[r1 * sw + c0], src[r1 * sw + c1]);
		return mix(py % 4, h0, h1);
	endfunction

	task automatic check_pixel(input string what, input pixel_t act, input pixel_t exp);
		if (act !== exp) begin
			$display("[ERROR] %0t ns %s: got %h expected %h", $time, what, act.raw, exp.raw);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic act, input logic exp);
		if (act !== exp) begin
			$display("[ERROR] %0t ns %s: got %b expected %b", $time, what, act, exp);
			errors++;
		end
	endtask

	task automatic fill_random(input int n);
		for (int k = 0; k < n; k++)
			src[k].raw = next_bits(PIXEL_WIDTH);
	endtask

	task automatic send_frame(input int n, input bit gaps);
		int idx;
		int tmo;
		bit sent;
		idx = 0;
		tmo = 0;
		sent = 1'b1;
		while (idx < n && tmo < LIMIT) begin
			@(negedge clk);
			// A beat that was not taken stays on the bus.
			if (sent || !s_valid) begin
				s_valid = !(gaps && next_bits(1) == 0);
				s_data  = src[idx];
				s_user  = (idx == 0);
				s_last  = ((idx % int'(s_width)) == int'(s_width) - 1);
			end
			sent = s_valid && s_ready;
			if (sent)
				idx++;
			tmo++;
		end
		if (idx < n) begin
			$display("timeout: source stream stuck after %0d of %0d pixels", idx, n);
			errors++;
		end
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	task automatic collect(input int n, input bit bp);
		int tmo;
		got_count = 0;
		tmo = 0;
		while (got_count < n && tmo < LIMIT) begin
			@(negedge clk);
			m_ready = bp ? (next_bits(1) != '0) : 1'b1;
			if (m_valid && m_ready) begin
				got[got_count]      = m_data;
				got_user[got_count] = m_user;
				got_last[got_count] = m_last;
				got_count++;
			end
			tmo++;
		end
		if (got_count < n) begin
			$display("timeout: only %0d of %0d output beats arrived", got_count, n);
			errors++;
		end
		m_ready = 1'b1;
	endtask

	task automatic scale_frame(input int sw, sh, mw, mh, input bit gaps, input bit bp);
		@(negedge clk);
		s_width  = SW_WIDTH'(sw);
		s_height = SH_WIDTH'(sh);
		m_width  = MW_WIDTH'(mw);
		m_height = MH_WIDTH'(mh);
		fsync    = 1'b1;
		@(negedge clk);
		fsync = 1'b0;
		fork
			send_frame(sw * sh, gaps);
			collect(mw * mh, bp);
		join
		repeat (8) begin
			@(negedge clk);
			if (m_valid) begin
				$display("extra output beat after a complete frame of %0d beats", mw * mh);
				errors++;
			end
		end
	endtask

	task automatic compare_model();
		int mw;
		mw = int'(m_width);
		for (int k = 0; k < got_count; k++) begin
			check_pixel("pixel", got[k], model_pixel(k % mw, k / mw));
			check_flag("user", got_user[k], k == 0);
			check_flag("last", got_last[k], (k % mw) == mw - 1);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before)
			tests_bad++;
		$display("%s: %s", name, (errors == err_before) ? "ok" : "mismatch");
	endtask

	task automatic test_reset_state();
		int e;
		e = errors;
		repeat (10) begin
			@(negedge clk);
			check_flag("o_s_ready before fsync", s_ready, 1'b0);
			check_flag("o_m_valid before fsync", m_valid, 1'b0);
		end
		finish_test("reset state", e);
	endtask

	task automatic test_identity();
		int e;
		e = errors;
		fill_random(12);
		scale_frame(4, 3, 4, 3, 1'b0, 1'b0);
		for (int k = 0; k < got_count; k++) begin
			check_pixel("identity pixel", got[k], src[k]);
			check_flag("user", got_user[k], k == 0);
			check_flag("last", got_last[k], (k % 4) == 3);
		end
		finish_test("identity 4x3", e);
	endtask

	task automatic test_blend();
		int e;
		e = errors;
		fill_random(20);
		scale_frame(5, 4, 8, 6, 1'b0, 1'b0);
		compare_model();
		finish_test("channel blend 5x4 to 8x6", e);
	endtask

	// Reuses the source pixels of the blend test.
	task automatic test_backpressure();
		int e;
		e = errors;
		scale_frame(5, 4, 8, 6, 1'b0, 1'b1);
		compare_model();
		finish_test("output back-pressure", e);
	endtask

	task automatic test_stalls_two_frames();
		int e;
		e = errors;
		fill_random(18);
		scale_frame(3, 6, 6, 12, 1'b1, 1'b0);
		compare_model();
		fill_random(4);
		scale_frame(2, 2, 4, 4, 1'b1, 1'b0);
		compare_model();
		finish_test("input stalls and second frame", e);
	endtask

	initial begin
		int tmo;
		fsync    = 1'b0;
		s_width  = '0;
		s_height = '0;
		m_width  = '0;
		m_height = '0;
		s_valid  = 1'b0;
		s_data   = '0;
		s_user   = 1'b0;
		s_last   = 1'b0;
		m_ready  = 1'b1;
		errors    = 0;
		tests_run = 0;
		tests_bad = 0;
		tmo = 0;
		while (frm_resetn !== 1'b1 && tmo < 10) begin
			@(negedge clk);
			tmo++;
		end
		if (frm_resetn !== 1'b1) begin
			$display("reset never released");
			errors++;
		end
		test_reset_state();
		test_identity();
		test_blend();
		test_backpressure();
		test_stalls_two_frames();
		$display("summary: %0d run, %0d with errors, %0d check errors",
			tests_run, tests_bad, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
scaler_pkg.sv
pixel_pkg.sv
linebuffer.sv
scaler_relay.sv
scaler_2d.sv
axis_scaler.sv
axis_scaler_properties.sv
tb_clkgen.sv
tb_axis_scaler.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axis_scaler -f vlog.f -o sim

status=0
./obj_dir/sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "tests failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation ok"
